/* sim.f */
logic/icache_cfg_pkg.sv
logic/icache_bus_pkg.sv
logic/icache_lookup.sv
logic/icache_refill.sv
logic/icache_respond.sv
logic/icache_top.sv
sim/icache_sva.sv
sim/icache_tb.sv

/* sim/icache_tb.sv */
// ----------------------------------------
// Table driven test with a random-gap bus model
// Memory word at byte address A is A ^ 5A5A_0000
// ----------------------------------------
module icache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {F_NO, F_YES, F_ANY} fill_e;  // Bus requests per read

  typedef struct packed {
    icache_bus_pkg::cpu_op_e op;
    logic [31:0]             adr;
    fill_e                   fill;
  } stim_t;

  localparam int NUM_STIM = 22;
  localparam int BP_FIRST = 12;                        // Back-pressure from here on
  localparam int TIMEOUT_CYCLES = 60 * NUM_STIM + 100;

  localparam stim_t STIM [NUM_STIM] = '{
    '{icache_bus_pkg::OP_READ,  32'h0000_0104, F_YES},  // Cold miss, set 0
    '{icache_bus_pkg::OP_READ,  32'h0000_0100, F_NO},
    '{icache_bus_pkg::OP_READ,  32'h0000_0108, F_NO},   // Back-to-back hits
    '{icache_bus_pkg::OP_READ,  32'h0000_010C, F_NO},
    '{icache_bus_pkg::OP_READ,  32'h0000_1040, F_YES},  // Three tags in set 4
    '{icache_bus_pkg::OP_READ,  32'h0000_2040, F_YES},
    '{icache_bus_pkg::OP_READ,  32'h0000_3040, F_YES},
    '{icache_bus_pkg::OP_READ,  32'h0000_1044, F_ANY},  // May be evicted
    '{icache_bus_pkg::OP_READ,  32'h0000_0100, F_NO},
    '{icache_bus_pkg::OP_FLUSH, 32'h0000_0000, F_NO},
    '{icache_bus_pkg::OP_READ,  32'h0000_0108, F_YES},  // Refetch after flush
    '{icache_bus_pkg::OP_READ,  32'h0000_010C, F_NO},
    '{icache_bus_pkg::OP_READ,  32'h0000_0250, F_YES},  // Back-pressure phase
    '{icache_bus_pkg::OP_READ,  32'h0000_0254, F_NO},
    '{icache_bus_pkg::OP_READ,  32'h0000_0258, F_NO},
    '{icache_bus_pkg::OP_READ,  32'h0000_025C, F_NO},
    '{icache_bus_pkg::OP_READ,  32'h0000_0104, F_NO},
    '{icache_bus_pkg::OP_READ,  32'h0000_0360, F_YES},
    '{icache_bus_pkg::OP_READ,  32'h0000_0364, F_NO},
    '{icache_bus_pkg::OP_READ,  32'h0000_0100, F_NO},
    '{icache_bus_pkg::OP_READ,  32'h8000_0010, F_YES},
    '{icache_bus_pkg::OP_READ,  32'h8000_001C, F_NO}
  };

  logic                     clk_i = 1'b1;  // First edge is a falling one
  logic                     rst_ni;
  logic                     req_valid_i;
  logic                     req_ready_o;
  icache_bus_pkg::cpu_req_t req_i;
  logic                     rsp_valid_o;
  logic                     rsp_ready_i;
  icache_cfg_pkg::word_t    rsp_data_o;
  icache_bus_pkg::bus_req_t bus_req_o;
  icache_bus_pkg::bus_rsp_t bus_rsp_i;

  int          seed = 32'h8904_d336;
  int          cycles = 0;
  int          bus_reqs = 0;      // Strobe handshakes so far
  int          last_reqs = 0;     // Count at previous response
  int          delta;
  logic [31:0] bus_adr_seen;
  logic        bp_en = 1'b0;
  stim_t       exp_q [$];         // Reads awaiting a response
  stim_t       exp_e;

  icache_top u_icache_top (.*);

  bind icache_top icache_sva u_sva (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o),
    .bus_req_o   (bus_req_o),
    .bus_rsp_i   (bus_rsp_i)
  );

  always #2 clk_i = ~clk_i;  // 4 ns period

  function automatic logic [31:0] mem_word(logic [31:0] adr);
    return {adr[31:2], 2'b00} ^ 32'h5A5A_0000;
  endfunction

  function automatic logic [31:0] line_adr(logic [31:0] adr);
    return {adr[31:4], 4'h0};  // 16-byte lines
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic bus_gap();
    int n;
    n = $random(seed) & 3;  // 0 to 3 idle cycles
    repeat (n) @(negedge clk_i);
  endtask

  // ----------------------------------------
  // Bus memory model
  // ----------------------------------------
  initial begin : bus_model
    logic [31:0] adr;
    bus_rsp_i = '0;
    forever begin
      @(negedge clk_i);
      if (bus_req_o.stb) begin
        adr = bus_req_o.adr;
        bus_gap();
        bus_rsp_i.stb_ack = 1'b1;
        @(negedge clk_i);
        bus_rsp_i.stb_ack = 1'b0;
        for (int b = 0; b < 4; b++) begin
          bus_gap();
          bus_rsp_i.ack = 1'b1;
          bus_rsp_i.q   = mem_word(adr + 32'(4 * b));  // Ascending words
          @(negedge clk_i);
          bus_rsp_i.ack = 1'b0;
        end
      end
    end
  end

  // Random stalls on the response side
  always @(negedge clk_i) rsp_ready_i = bp_en ? (($random(seed) & 3) != 0) : 1'b1;

  // ----------------------------------------
  // Response monitor and timeout
  // ----------------------------------------
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
    if (u_icache_top.u_sva.fail_cnt != 0) fail_run("A protocol assertion failed");
    if (rst_ni && bus_req_o.stb && bus_rsp_i.stb_ack) begin
      bus_reqs++;
      bus_adr_seen = bus_req_o.adr;
    end
    if (rst_ni && rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) fail_run("Response arrived with no read pending");
      exp_e = exp_q.pop_front();
      check("rsp_data_o", rsp_data_o, mem_word(exp_e.adr));
      delta = bus_reqs - last_reqs;
      case (exp_e.fill)
        F_YES: begin
          check("bus request count", delta, 1);
          check("bus_req_o.adr", bus_adr_seen, line_adr(exp_e.adr));
        end
        F_NO:  check("bus request count", delta, 0);
        default: if (delta > 1) fail_run("A single read caused more than one bus request");
      endcase
      last_reqs = bus_reqs;
    end
  end

  // Drive one table entry and wait for acceptance
  task automatic apply(int i);
    int wait_cyc;
    wait_cyc    = 0;
    req_valid_i = 1'b1;
    req_i.op    = STIM[i].op;
    req_i.adr   = STIM[i].adr;
    @(posedge clk_i);
    while (!req_ready_o) begin
      wait_cyc++;
      @(posedge clk_i);
    end
    if (STIM[i].op == icache_bus_pkg::OP_READ) begin
      exp_q.push_back(STIM[i]);
    end
    // Hit after hit with no stall needs no gap
    if (i > 0 && i < BP_FIRST && STIM[i].fill == F_NO && STIM[i-1].fill == F_NO &&
        STIM[i].op == icache_bus_pkg::OP_READ && STIM[i-1].op == icache_bus_pkg::OP_READ) begin
      check("accept wait cycles", wait_cyc, 0);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    rst_ni      = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b1;
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Idle after reset
    repeat (5) begin
      @(posedge clk_i);
      check("rsp_valid_o", rsp_valid_o, 0);
      check("bus_req_o.stb", bus_req_o.stb, 0);
      check("req_ready_o", req_ready_o, 1);
    end
    @(negedge clk_i);

    for (int i = 0; i < NUM_STIM; i++) begin
      if (i == BP_FIRST) bp_en = 1'b1;
      apply(i);
    end

    while (exp_q.size() != 0) @(posedge clk_i);  // Drain, timeout guards
    repeat (4) @(posedge clk_i);
    check("rsp_valid_o", rsp_valid_o, 0);  // No leftover response
    check("bus_req_o.stb", bus_req_o.stb, 0);

    @(negedge clk_i);
    if (u_icache_top.u_sva.fail_cnt != 0) begin
      fail_run("A protocol assertion failed");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

/* sim/icache_sva.sv */
// ----------------------------------------
// Protocol checks for the cache top level
// Bound into icache_top, sampled on clk_i
// ----------------------------------------
module icache_sva (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     rsp_valid_o,
  input logic                     rsp_ready_i,
  input icache_cfg_pkg::word_t    rsp_data_o,
  input icache_bus_pkg::bus_req_t bus_req_o,
  input icache_bus_pkg::bus_rsp_t bus_rsp_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;  // Failed assertions so far

  // Response holds under back-pressure
  rsp_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o))
    else begin
      fail_cnt++;
      $error("rsp_valid_o or rsp_data_o changed while rsp_ready_i was low");
    end

  // Strobe and its address wait for stb_ack
  stb_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o.stb && !bus_rsp_i.stb_ack |=> bus_req_o.stb && $stable(bus_req_o.adr))
    else begin
      fail_cnt++;
      $error("bus_req_o.stb or its address dropped before stb_ack");
    end

  // Quiet outputs in reset
  rst_quiet_a : assert property (@(posedge clk_i)
    !rst_ni |-> !rsp_valid_o && !bus_req_o.stb)
    else begin
      fail_cnt++;
      $error("rsp_valid_o or bus_req_o.stb high during reset");
    end

endmodule

/* logic/icache_top.sv */
// ----------------------------------------
// Read-only 2-way instruction cache
// ----------------------------------------
module icache_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // CPU side
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  icache_bus_pkg::cpu_req_t   req_i,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output icache_cfg_pkg::word_t      rsp_data_o,

  // Bus side
  output icache_bus_pkg::bus_req_t   bus_req_o,
  input  icache_bus_pkg::bus_rsp_t   bus_rsp_i
);

  // Front-end to arrays
  logic                              rd_en;
  icache_cfg_pkg::idx_t              rd_idx;
  icache_cfg_pkg::tag_t              cmp_tag;
  logic                              flush;
  logic                              hit;
  icache_cfg_pkg::line_t             hit_line;

  // Front-end to refill
  logic                              miss_valid;
  logic [icache_cfg_pkg::PLEN-1:0]   miss_adr;
  icache_bus_pkg::fill_t             fill;    // Shared by arrays and front-end

  icache_lookup u_lookup (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_en_i    (rd_en),
    .rd_idx_i   (rd_idx),
    .cmp_tag_i  (cmp_tag),
    .flush_i    (flush),
    .fill_i     (fill),
    .hit_o      (hit),
    .hit_line_o (hit_line)
  );

  icache_refill u_refill (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .miss_valid_i (miss_valid),
    .miss_adr_i   (miss_adr),
    .bus_req_o    (bus_req_o),
    .bus_rsp_i    (bus_rsp_i),
    .fill_o       (fill)
  );

  icache_respond u_respond (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .rd_en_o      (rd_en),
    .rd_idx_o     (rd_idx),
    .cmp_tag_o    (cmp_tag),
    .flush_o      (flush),
    .hit_i        (hit),
    .hit_line_i   (hit_line),
    .miss_valid_o (miss_valid),
    .miss_adr_o   (miss_adr),
    .fill_i       (fill),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_data_o   (rsp_data_o)
  );

endmodule

/* logic/icache_respond.sv */
// ----------------------------------------
// Single stage front-end, responses in order
// Flush takes no stage and gives no response
// ----------------------------------------
module icache_respond (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  // CPU request
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  input  icache_bus_pkg::cpu_req_t           req_i,

  // Lookup control
  output logic                               rd_en_o,
  output icache_cfg_pkg::idx_t               rd_idx_o,
  output icache_cfg_pkg::tag_t               cmp_tag_o,
  output logic                               flush_o,
  input  logic                               hit_i,
  input  icache_cfg_pkg::line_t              hit_line_i,

  // Refill link
  output logic                               miss_valid_o,
  output logic [icache_cfg_pkg::PLEN-1:0]    miss_adr_o,
  input  icache_bus_pkg::fill_t              fill_i,

  // CPU response
  output logic                               rsp_valid_o,
  input  logic                               rsp_ready_i,
  output icache_cfg_pkg::word_t              rsp_data_o
);

  typedef enum logic [1:0] {
    EMPTY,   // Nothing held
    LOOKUP,  // Arrays read, hit known
    MISS,    // Waiting for refill
    DONE     // Refilled word held
  } stage_e;

  stage_e                             stage_q;
  logic [icache_cfg_pkg::PLEN-1:0]    adr_q;   // Accepted address
  icache_cfg_pkg::word_t              data_q;  // Word from the fill
  icache_cfg_pkg::offs_t              offs;
  logic                               rsp_fire;
  logic                               accept;

  assign offs = adr_q[icache_cfg_pkg::BYTE_BITS +: icache_cfg_pkg::OFFS_BITS];

  // ----------------------------------------
  // Response side
  // ----------------------------------------
  assign rsp_valid_o = (stage_q == LOOKUP && hit_i) || (stage_q == DONE);
  assign rsp_data_o  = (stage_q == DONE) ? data_q : hit_line_i[offs];
  assign rsp_fire    = rsp_valid_o & rsp_ready_i;

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  assign req_ready_o = (stage_q == EMPTY) || rsp_fire;  // Low under back-pressure
  assign accept      = req_valid_i & req_ready_o;

  assign rd_en_o  = accept & (req_i.op == icache_bus_pkg::OP_READ);
  assign flush_o  = accept & (req_i.op == icache_bus_pkg::OP_FLUSH);
  assign rd_idx_o = req_i.adr[icache_cfg_pkg::BYTE_BITS + icache_cfg_pkg::OFFS_BITS +:
                              icache_cfg_pkg::IDX_BITS];

  assign cmp_tag_o = adr_q[icache_cfg_pkg::PLEN-1 -: icache_cfg_pkg::TAG_BITS];

  // Miss held until the fill lands
  assign miss_valid_o = (stage_q == LOOKUP && !hit_i) || (stage_q == MISS);
  assign miss_adr_o   = {adr_q[icache_cfg_pkg::PLEN-1:
                               icache_cfg_pkg::BYTE_BITS + icache_cfg_pkg::OFFS_BITS],
                         {(icache_cfg_pkg::BYTE_BITS + icache_cfg_pkg::OFFS_BITS){1'b0}}};

  // ----------------------------------------
  // Stage FSM
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= EMPTY;
    end else if (rd_en_o) begin
      stage_q <= LOOKUP;                   // Stage freed or empty this cycle
    end else if (rsp_fire) begin
      stage_q <= EMPTY;
    end else if (stage_q == LOOKUP && !hit_i) begin
      stage_q <= MISS;
    end else if (stage_q == MISS && fill_i.we) begin
      stage_q <= DONE;
    end
  end

  // Address and refill word
  always_ff @(posedge clk_i) begin
    if (rd_en_o) adr_q <= req_i.adr;
    if (stage_q == MISS && fill_i.we) data_q <= fill_i.line[offs];
  end

endmodule

/* logic/icache_refill.sv */
// ----------------------------------------
// One line burst at a time, words in ascending order
// Fill way taken from a free running LFSR
// ----------------------------------------
module icache_refill (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  // Miss from the front-end
  input  logic                               miss_valid_i,  // Held until fill
  input  logic [icache_cfg_pkg::PLEN-1:0]    miss_adr_i,    // Line aligned

  // Bus
  output icache_bus_pkg::bus_req_t           bus_req_o,
  input  icache_bus_pkg::bus_rsp_t           bus_rsp_i,

  // Line write into the arrays
  output icache_bus_pkg::fill_t              fill_o
);

  typedef enum logic [1:0] {
    IDLE,   // Wait for a miss
    REQ,    // Strobe out
    BURST,  // Collect beats
    WRITE   // Fill pulse
  } state_e;

  state_e                             state_q;
  logic [icache_cfg_pkg::PLEN-1:0]    adr_q;    // Captured line address
  icache_cfg_pkg::offs_t              beat_q;   // Beats received
  icache_cfg_pkg::line_t              line_q;   // Line assembly buffer
  logic [6:0]                         lfsr_q;   // Way choice
  logic                               filling;

  assign filling = (state_q != IDLE);

  // ----------------------------------------
  // Burst FSM
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      beat_q  <= '0;
    end else begin
      unique case (state_q)
        IDLE:  if (miss_valid_i) state_q <= REQ;
        REQ: begin
          if (bus_rsp_i.stb_ack) begin
            state_q <= BURST;
            beat_q  <= '0;
          end
        end
        BURST: begin
          if (bus_rsp_i.ack) begin
            beat_q <= beat_q + 1'b1;
            // Last beat ends the burst
            if (beat_q == icache_cfg_pkg::offs_t'(icache_cfg_pkg::LINE_WORDS - 1)) begin
              state_q <= WRITE;
            end
          end
        end
        WRITE: state_q <= IDLE;  // One cycle only
        default: state_q <= IDLE;
      endcase
    end
  end

  // Address and line payload
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && miss_valid_i) adr_q <= miss_adr_i;
    if (state_q == BURST && bus_rsp_i.ack) begin
      // Shift down, newest word enters at the top
      line_q <= {bus_rsp_i.q, line_q[icache_cfg_pkg::LINE_WORDS-1:1]};
    end
  end

  // ----------------------------------------
  // Replacement LFSR
  // ----------------------------------------
  // Frozen during a refill so the way stays put
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;
    end else if (!filling) begin
      lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ~^ lfsr_q[5]};
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  always_comb begin
    bus_req_o.stb = (state_q == REQ);  // Held until stb_ack
    bus_req_o.adr = adr_q;

    fill_o.we   = (state_q == WRITE);
    fill_o.idx  = adr_q[icache_cfg_pkg::BYTE_BITS + icache_cfg_pkg::OFFS_BITS +:
                        icache_cfg_pkg::IDX_BITS];
    fill_o.tag  = adr_q[icache_cfg_pkg::PLEN-1 -: icache_cfg_pkg::TAG_BITS];
    fill_o.way  = icache_cfg_pkg::way_t'(1) << lfsr_q[0];  // Low bit picks the way
    fill_o.line = line_q;
  end

endmodule

/* logic/icache_lookup.sv */
// ----------------------------------------
// Tag and data arrays read synchronously
// Hit and hit line hold until the next read
// ----------------------------------------
module icache_lookup (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Read port
  input  logic                  rd_en_i,
  input  icache_cfg_pkg::idx_t  rd_idx_i,
  input  icache_cfg_pkg::tag_t  cmp_tag_i,  // Tag of the pending read

  input  logic                  flush_i,    // Clear all valid bits
  input  icache_bus_pkg::fill_t fill_i,

  output logic                  hit_o,
  output icache_cfg_pkg::line_t hit_line_o
);

  icache_cfg_pkg::way_t  way_hit;                               // Per way compare
  icache_cfg_pkg::line_t way_line [icache_cfg_pkg::WAYS];       // Registered lines

  // ----------------------------------------
  // Per way storage
  // ----------------------------------------
  for (genvar w = 0; w < icache_cfg_pkg::WAYS; w++) begin : g_way

    icache_cfg_pkg::tag_t  tag_mem  [icache_cfg_pkg::SETS];
    icache_cfg_pkg::line_t line_mem [icache_cfg_pkg::SETS];

    icache_cfg_pkg::tag_t        tag_q;    // Tag read out
    icache_cfg_pkg::line_t       line_q;   // Line read out
    logic [icache_cfg_pkg::SETS-1:0] valid_q;  // Valid bits in flops
    logic                        rd_vld_q; // Valid bit read out

    logic                        fill_we;

    assign fill_we = fill_i.we & fill_i.way[w];

    // Array write and synchronous read
    always_ff @(posedge clk_i) begin
      if (fill_we) begin
        tag_mem[fill_i.idx]  <= fill_i.tag;
        line_mem[fill_i.idx] <= fill_i.line;
      end
      if (rd_en_i) begin
        tag_q  <= tag_mem[rd_idx_i];
        line_q <= line_mem[rd_idx_i];
      end
    end

    // Valid bits, flush wins over fill
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= '0;
      end else if (flush_i) begin
        valid_q <= '0;
      end else if (fill_we) begin
        valid_q[fill_i.idx] <= 1'b1;
      end
    end

    // Valid sampled along with the arrays
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rd_vld_q <= 1'b0;
      end else if (rd_en_i) begin
        rd_vld_q <= valid_q[rd_idx_i];
      end
    end

    assign way_hit[w]  = rd_vld_q & (tag_q == cmp_tag_i);
    assign way_line[w] = line_q;

  end : g_way

  // ----------------------------------------
  // Hit select
  // ----------------------------------------
  assign hit_o = |way_hit;

  // At most one way holds a given tag
  always_comb begin
    hit_line_o = '0;
    for (int i = 0; i < icache_cfg_pkg::WAYS; i++) begin
      if (way_hit[i]) hit_line_o = way_line[i];
    end
  end

endmodule

/* logic/icache_bus_pkg.sv */
// ----------------------------------------
// CPU request, bus and fill records
// Bus address is always line aligned
// ----------------------------------------
package icache_bus_pkg;

  // Request opcodes
  typedef enum logic {
    OP_READ  = 1'b0,  // Fetch one word
    OP_FLUSH = 1'b1   // Invalidate whole cache
  } cpu_op_e;

  // CPU side request, held stable while valid waits
  typedef struct packed {
    cpu_op_e                            op;
    logic [icache_cfg_pkg::PLEN-1:0]    adr;  // Byte address of word
  } cpu_req_t;

  // Cache to bus
  typedef struct packed {
    logic                               stb;  // Held until stb_ack
    logic [icache_cfg_pkg::PLEN-1:0]    adr;  // Burst start address
  } bus_req_t;

  // Bus to cache
  typedef struct packed {
    logic                               stb_ack;  // Strobe taken
    logic                               ack;      // One per data beat
    icache_cfg_pkg::word_t              q;        // Beat data
  } bus_rsp_t;

  // Line write from refill into the arrays
  typedef struct packed {
    logic                               we;    // Single cycle pulse
    icache_cfg_pkg::idx_t               idx;
    icache_cfg_pkg::tag_t               tag;
    icache_cfg_pkg::way_t               way;   // One-hot
    icache_cfg_pkg::line_t              line;
  } fill_t;

endpackage

/* logic/icache_cfg_pkg.sv */
// ----------------------------------------
// Fixed geometry of 2 ways, 16 sets, 16-byte lines
// Address fields follow tag | index | word offset | byte
// ----------------------------------------
package icache_cfg_pkg;

  // Widths
  localparam int XLEN       = 32;  // Data word
  localparam int PLEN       = 32;  // Byte address

  // Geometry
  localparam int LINE_WORDS = 4;   // Also beats per burst
  localparam int WAYS       = 2;
  localparam int SETS       = 16;

  // Address split
  localparam int BYTE_BITS  = 2;   // Byte in word
  localparam int OFFS_BITS  = 2;   // Word in line
  localparam int IDX_BITS   = 4;   // log2 of SETS
  localparam int TAG_BITS   = PLEN - IDX_BITS - OFFS_BITS - BYTE_BITS;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [TAG_BITS-1:0]  tag_t;
  typedef logic [IDX_BITS-1:0]  idx_t;
  typedef logic [OFFS_BITS-1:0] offs_t;

  // Word 0 sits in the low bits
  typedef word_t [LINE_WORDS-1:0] line_t;

  // One-hot way select
  typedef logic [WAYS-1:0] way_t;

endpackage
